/* hdl/range_consts.svh */
// Widths and depths of the range monitor, included by the package, RTL and testbench
`ifndef RANGE_CONSTS_SVH
`define RANGE_CONSTS_SVH

// Sample payload and sequence tag
`define SAMPLE_W 8
`define SEQ_W 8

// Saturating event and drop counters
`define CNT_W 16

// Sample buffer entries, power of two
`define FIFO_DEPTH 8

// APB register port
`define APB_AW 5
`define APB_DW 32

`endif

/* hdl/range_pkg.sv */
// Types shared by the range monitor RTL and testbench, compiled before the modules
package range_pkg;

`include "range_consts.svh"

    // Tagged sample from capture through the FIFO to the checker
    typedef struct packed {
        logic                 chan;
        logic [`SEQ_W-1:0]    seq;
        logic [`SAMPLE_W-1:0] data;
    } sample_t;

    // Result of one range check
    typedef struct packed {
        logic                 chan;
        logic [`SEQ_W-1:0]    seq;
        logic [`SAMPLE_W-1:0] data;
        logic                 below;
        logic                 above;
    } alarm_t;

    // Inclusive bounds of both channels
    typedef struct packed {
        logic [`SAMPLE_W-1:0] low0;
        logic [`SAMPLE_W-1:0] high0;
        logic [`SAMPLE_W-1:0] low1;
        logic [`SAMPLE_W-1:0] high1;
    } bounds_t;

    // APB byte address map
    typedef enum logic [`APB_AW-1:0] {
        REG_CTRL  = 'h00,
        REG_LOW0  = 'h04,
        REG_HIGH0 = 'h08,
        REG_LOW1  = 'h0C,
        REG_HIGH1 = 'h10,
        REG_EVT0  = 'h14,
        REG_EVT1  = 'h18,
        REG_DROP  = 'h1C
    } reg_addr_e;

endpackage

/* hdl/sample_capture.sv */
// Input capture stage: registers samples, tags them with a sequence number, pushes or drops
`timescale 1ns/1ps

`include "range_consts.svh"

module sample_capture
    import range_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_chan,
    input  logic [`SAMPLE_W-1:0] in_data,
    input  logic                 full,
    output logic                 push_valid,
    output sample_t              push_item,
    output logic                 drop_inc
);

    logic              valid_q;
    sample_t           item_q;
    logic [`SEQ_W-1:0] seq_cnt;

    // Every accepted sample takes a tag, even when it ends up dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            seq_cnt <= '0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (in_valid) begin
            item_q.chan <= in_chan;
            item_q.seq  <= seq_cnt;
            item_q.data <= in_data;
        end
    end

    // Full at the push edge turns the push into a drop
    assign push_valid = valid_q & ~full;
    assign drop_inc   = valid_q & full;
    assign push_item  = item_q;

endmodule

/* hdl/sample_fifo.sv */
// Show-ahead FIFO of tagged samples between the capture stage and the checker
`timescale 1ns/1ps

`include "range_consts.svh"

module sample_fifo
    import range_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push_valid,
    input  sample_t push_item,
    input  logic    pop,
    output sample_t pop_item,
    output logic    full,
    output logic    empty
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    sample_t       mem [`FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_valid & ~full;
    assign do_pop  = pop & ~empty;

    // Extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_item;
        end
    end

    // Head entry is visible while not empty
    assign pop_item = mem[rd_ptr[AW-1:0]];

endmodule

/* hdl/range_regs.sv */
// APB register block with enable, per-channel bounds and saturating event and drop counters
`timescale 1ns/1ps

`include "range_consts.svh"

module range_regs
    import range_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [`APB_DW-1:0] pwdata,
    output logic [`APB_DW-1:0] prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               enable,
    output bounds_t            bounds,
    input  logic               evt0_inc,
    input  logic               evt1_inc,
    input  logic               drop_inc
);

    reg_addr_e         addr;
    logic              mapped;
    logic              access;
    logic              wr;
    logic [`CNT_W-1:0] evt0_cnt;
    logic [`CNT_W-1:0] evt1_cnt;
    logic [`CNT_W-1:0] drop_cnt;

    // Clear beats increment, counting stops at all ones
    function automatic logic [`CNT_W-1:0] next_count(input logic [`CNT_W-1:0] cnt,
                                                     input logic clr,
                                                     input logic inc);
        if (clr) begin
            return '0;
        end else if (inc && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    assign addr    = reg_addr_e'(paddr);
    assign access  = psel & penable;
    assign wr      = access & pwrite & mapped;
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    // Address decode and read mux
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (addr)
            REG_CTRL:  prdata = {{(`APB_DW-1){1'b0}}, enable};
            REG_LOW0:  prdata = {{(`APB_DW-`SAMPLE_W){1'b0}}, bounds.low0};
            REG_HIGH0: prdata = {{(`APB_DW-`SAMPLE_W){1'b0}}, bounds.high0};
            REG_LOW1:  prdata = {{(`APB_DW-`SAMPLE_W){1'b0}}, bounds.low1};
            REG_HIGH1: prdata = {{(`APB_DW-`SAMPLE_W){1'b0}}, bounds.high1};
            REG_EVT0:  prdata = {{(`APB_DW-`CNT_W){1'b0}}, evt0_cnt};
            REG_EVT1:  prdata = {{(`APB_DW-`CNT_W){1'b0}}, evt1_cnt};
            REG_DROP:  prdata = {{(`APB_DW-`CNT_W){1'b0}}, drop_cnt};
            default:   mapped = 1'b0;
        endcase
    end

    // Control and bounds, full range after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable       <= 1'b0;
            bounds.low0  <= '0;
            bounds.high0 <= '1;
            bounds.low1  <= '0;
            bounds.high1 <= '1;
        end else if (wr) begin
            case (addr)
                REG_CTRL:  enable       <= pwdata[0];
                REG_LOW0:  bounds.low0  <= pwdata[`SAMPLE_W-1:0];
                REG_HIGH0: bounds.high0 <= pwdata[`SAMPLE_W-1:0];
                REG_LOW1:  bounds.low1  <= pwdata[`SAMPLE_W-1:0];
                REG_HIGH1: bounds.high1 <= pwdata[`SAMPLE_W-1:0];
                default:   ;
            endcase
        end
    end

    // Any write to a counter address clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evt0_cnt <= '0;
            evt1_cnt <= '0;
            drop_cnt <= '0;
        end else begin
            evt0_cnt <= next_count(evt0_cnt, wr && (addr == REG_EVT0), evt0_inc);
            evt1_cnt <= next_count(evt1_cnt, wr && (addr == REG_EVT1), evt1_inc);
            drop_cnt <= next_count(drop_cnt, wr && (addr == REG_DROP), drop_inc);
        end
    end

endmodule

/* hdl/range_checker.sv */
// Range checker: pops the FIFO and compares each sample to its channel bounds in three stages
`timescale 1ns/1ps

`include "range_consts.svh"

module range_checker
    import range_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  bounds_t bounds,
    input  logic    empty,
    input  sample_t pop_item,
    output logic    pop,
    output logic    alarm_valid,
    output alarm_t  alarm,
    output logic    evt0_inc,
    output logic    evt1_inc
);

    logic                 s1_valid;
    sample_t              s1_item;
    logic [`SAMPLE_W-1:0] s1_low;
    logic [`SAMPLE_W-1:0] s1_high;

    logic                 s2_valid;
    sample_t              s2_item;
    logic                 s2_below;
    logic                 s2_above;

    // One pop per cycle whenever the head is valid
    assign pop = enable & ~empty;

    // Valid chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            alarm_valid <= 1'b0;
            evt0_inc    <= 1'b0;
            evt1_inc    <= 1'b0;
        end else begin
            s1_valid    <= pop;
            s2_valid    <= s1_valid;
            alarm_valid <= s2_valid;
            evt0_inc    <= s2_valid & ~s2_item.chan & (s2_below | s2_above);
            evt1_inc    <= s2_valid & s2_item.chan & (s2_below | s2_above);
        end
    end

    // Stage 1 picks the bounds of the sample's channel
    always_ff @(posedge clk) begin
        if (pop) begin
            s1_item <= pop_item;
            s1_low  <= pop_item.chan ? bounds.low1 : bounds.low0;
            s1_high <= pop_item.chan ? bounds.high1 : bounds.high0;
        end
    end

    // Stage 2 compares, bounds themselves are in range
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_item  <= s1_item;
            s2_below <= (s1_item.data < s1_low);
            s2_above <= (s1_item.data > s1_high);
        end
    end

    // Stage 3 result word
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            alarm.chan  <= s2_item.chan;
            alarm.seq   <= s2_item.seq;
            alarm.data  <= s2_item.data;
            alarm.below <= s2_below;
            alarm.above <= s2_above;
        end
    end

endmodule

/* hdl/range_monitor_top.sv */
// Two-channel sample range monitor top: capture, FIFO, checker and APB register block
`timescale 1ns/1ps

`include "range_consts.svh"

module range_monitor_top
    import range_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_chan,
    input  logic [`SAMPLE_W-1:0] in_data,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [`APB_AW-1:0]   paddr,
    input  logic [`APB_DW-1:0]   pwdata,
    output logic [`APB_DW-1:0]   prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 alarm_valid,
    output alarm_t               alarm
);

    logic    push_valid;
    sample_t push_item;
    logic    full;
    logic    empty;
    logic    pop;
    sample_t pop_item;
    logic    enable;
    bounds_t bounds;
    logic    evt0_inc;
    logic    evt1_inc;
    logic    drop_inc;

    sample_capture u_capture (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_chan(in_chan), .in_data(in_data),
        .full(full), .push_valid(push_valid), .push_item(push_item),
        .drop_inc(drop_inc)
    );

    sample_fifo u_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_valid(push_valid), .push_item(push_item),
        .pop(pop), .pop_item(pop_item), .full(full), .empty(empty)
    );

    range_checker u_checker (
        .clk(clk), .rst_n(rst_n), .enable(enable), .bounds(bounds),
        .empty(empty), .pop_item(pop_item), .pop(pop),
        .alarm_valid(alarm_valid), .alarm(alarm),
        .evt0_inc(evt0_inc), .evt1_inc(evt1_inc)
    );

    range_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .enable(enable), .bounds(bounds),
        .evt0_inc(evt0_inc), .evt1_inc(evt1_inc), .drop_inc(drop_inc)
    );

endmodule

/* sim/range_monitor_tasks.svh */
// APB access, sample stimulus, compare tasks and directed tests that the testbench top includes

// LCG step with the sample taken from the upper bits
function automatic logic [`SAMPLE_W-1:0] random_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[16 +: `SAMPLE_W];
endfunction

task automatic fail_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic check_alarm(input alarm_t got, input alarm_t exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH alarm got %h expected %h", got, exp));
    end
endtask

task automatic check_reg(input string name, input logic [`APB_DW-1:0] got,
                         input logic [`APB_DW-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH pslverr got %h expected %h", got, exp));
    end
endtask

// Zero wait states
task automatic check_ready(input logic got);
    if (got !== 1'b1) begin
        fail_run($sformatf("MISMATCH pready got %h expected %h", got, 1'b1));
    end
endtask

task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    sb.delete();
    exp_low     = '{'0, '0};
    exp_high    = '{'1, '1};
    exp_evt     = '{0, 0};
    exp_drop    = 0;
    exp_enable  = 1'b0;
    seq_next    = '0;
    alarm_count = 0;
endtask

// Setup cycle then access cycle with read data and error sampled mid access cycle
task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
                          input logic [`APB_DW-1:0] wdata,
                          output logic [`APB_DW-1:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_ready(pready);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic reg_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
                         input logic exp_err);
    logic [`APB_DW-1:0] rdata;
    logic               err;
    apb_access(1'b1, addr, data, rdata, err);
    check_err(err, exp_err);
endtask

task automatic reg_check(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] exp);
    logic [`APB_DW-1:0] rdata;
    logic               err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_err(err, 1'b0);
    check_reg($sformatf("prdata at 0x%h", addr), rdata, exp);
endtask

task automatic check_all_regs();
    reg_check(REG_CTRL, `APB_DW'(exp_enable));
    reg_check(REG_LOW0, `APB_DW'(exp_low[0]));
    reg_check(REG_HIGH0, `APB_DW'(exp_high[0]));
    reg_check(REG_LOW1, `APB_DW'(exp_low[1]));
    reg_check(REG_HIGH1, `APB_DW'(exp_high[1]));
    reg_check(REG_EVT0, `APB_DW'(exp_evt[0]));
    reg_check(REG_EVT1, `APB_DW'(exp_evt[1]));
    reg_check(REG_DROP, `APB_DW'(exp_drop));
endtask

task automatic set_enable(input logic en);
    reg_write(REG_CTRL, `APB_DW'(en), 1'b0);
    exp_enable = en;
endtask

task automatic write_bounds(input logic [`SAMPLE_W-1:0] lo0, input logic [`SAMPLE_W-1:0] hi0,
                            input logic [`SAMPLE_W-1:0] lo1, input logic [`SAMPLE_W-1:0] hi1);
    reg_write(REG_LOW0, `APB_DW'(lo0), 1'b0);
    reg_write(REG_HIGH0, `APB_DW'(hi0), 1'b0);
    reg_write(REG_LOW1, `APB_DW'(lo1), 1'b0);
    reg_write(REG_HIGH1, `APB_DW'(hi1), 1'b0);
    exp_low  = '{lo0, lo1};
    exp_high = '{hi0, hi1};
endtask

// Drives one sample for one cycle and kept says whether it reaches the FIFO
task automatic send_sample(input logic chan, input logic [`SAMPLE_W-1:0] data,
                           input logic kept);
    alarm_t exp;
    exp.chan  = chan;
    exp.seq   = seq_next;
    exp.data  = data;
    // Inclusive bounds
    exp.below = (data < exp_low[chan]);
    exp.above = (data > exp_high[chan]);
    if (kept) begin
        sb.push_back(exp);
        if (exp.below || exp.above) begin
            exp_evt[chan]++;
        end
    end else begin
        exp_drop++;
    end
    seq_next++;
    in_valid = 1'b1;
    in_chan  = chan;
    in_data  = data;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
endtask

task automatic wait_drain();
    int n;
    n = 0;
    while ((sb.size() != 0) && (n < 40)) begin
        @(posedge clk);
        n++;
    end
    if (sb.size() != 0) begin
        fail_run("Expected alarms did not come out in time");
    end
    // Let the last event pulse reach its counter
    repeat (2) @(posedge clk);
    #1;
endtask

task automatic test_reset_values();
    logic [`SAMPLE_W-1:0] r;
    check_all_regs();
    set_enable(1'b1);
    for (int i = 0; i < 20; i++) begin
        r = random_byte();
        send_sample(r[7], random_byte(), 1'b1);
    end
    wait_drain();
endtask

task automatic test_overflow();
    logic [`SAMPLE_W-1:0] r;
    int                   seen;
    set_enable(1'b0);
    seen = alarm_count;
    // Only the first FIFO_DEPTH samples fit in the FIFO
    for (int i = 0; i < 12; i++) begin
        r = random_byte();
        send_sample(r[7], random_byte(), i < `FIFO_DEPTH);
    end
    repeat (4) @(posedge clk);
    #1;
    if (alarm_count != seen) begin
        fail_run("An alarm came out while the checker was disabled");
    end
    reg_check(REG_DROP, `APB_DW'(exp_drop));
    set_enable(1'b1);
    wait_drain();
    send_sample(1'b0, random_byte(), 1'b1);
    wait_drain();
endtask

task automatic test_bounds();
    logic [`SAMPLE_W-1:0] r;
    set_enable(1'b1);
    write_bounds(8'h30, 8'hC0, 8'h50, 8'h90);
    // Each bound and its outside neighbour
    for (int c = 0; c < 2; c++) begin
        send_sample(c[0], exp_low[c] - 1'b1, 1'b1);
        send_sample(c[0], exp_low[c], 1'b1);
        send_sample(c[0], exp_high[c], 1'b1);
        send_sample(c[0], exp_high[c] + 1'b1, 1'b1);
    end
    for (int i = 0; i < 24; i++) begin
        r = random_byte();
        send_sample(r[7], random_byte(), 1'b1);
    end
    wait_drain();
    reg_check(REG_EVT0, `APB_DW'(exp_evt[0]));
    reg_check(REG_EVT1, `APB_DW'(exp_evt[1]));
endtask

task automatic test_counter_clear();
    reg_write(REG_EVT0, 32'h0, 1'b0);
    exp_evt[0] = 0;
    reg_check(REG_EVT0, 32'h0);
    reg_check(REG_EVT1, `APB_DW'(exp_evt[1]));
    reg_check(REG_DROP, `APB_DW'(exp_drop));
    reg_write(REG_DROP, 32'h1, 1'b0);
    exp_drop = 0;
    reg_check(REG_DROP, 32'h0);
endtask

task automatic test_unmapped();
    logic [`APB_DW-1:0] rdata;
    logic               err;
    check_all_regs();
    // Unmapped neighbours of LOW0 and EVT1 in the same word slots
    reg_write(5'h05, 32'hFFFF_FFFF, 1'b1);
    reg_write(5'h1A, 32'hFFFF_FFFF, 1'b1);
    apb_access(1'b0, 5'h1E, '0, rdata, err);
    check_err(err, 1'b1);
    check_all_regs();
endtask

/* sim/tb_range_monitor.sv */
// Testbench top for the range monitor: clock, reset, watchdog, alarm scoreboard and test order
`timescale 1ns/1ps

`include "range_consts.svh"

module tb_range_monitor
    import range_pkg::*;
();

    // Samples sent over all tests, sizes the watchdog
    localparam int NUM_SAMPLES = 65;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_chan;
    logic [`SAMPLE_W-1:0] in_data;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`APB_AW-1:0]   paddr;
    logic [`APB_DW-1:0]   pwdata;
    logic [`APB_DW-1:0]   prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 alarm_valid;
    alarm_t               alarm;

    // Reference model state
    alarm_t               sb[$];
    logic [`SAMPLE_W-1:0] exp_low [2];
    logic [`SAMPLE_W-1:0] exp_high [2];
    int unsigned          exp_evt [2];
    int unsigned          exp_drop;
    logic                 exp_enable;
    logic [`SEQ_W-1:0]    seq_next;
    int                   alarm_count;
    logic [31:0]          lcg_state;

    range_monitor_top uut (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_chan(in_chan), .in_data(in_data),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .alarm_valid(alarm_valid), .alarm(alarm)
    );

`include "range_monitor_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        #((NUM_SAMPLES + 200) * 4);
        fail_run("Timeout: the test sequence did not finish in time");
    end

    // Alarm scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && alarm_valid) begin
            alarm_count++;
            if (sb.size() == 0) begin
                fail_run("An alarm came out while no sample result was expected");
            end else begin
                check_alarm(alarm, sb.pop_front());
            end
        end
    end

    initial begin
        in_valid  = 1'b0;
        in_chan   = 1'b0;
        in_data   = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lcg_state = 32'h203;
        apply_reset();
        test_reset_values();
        // Fresh seq numbering for the overflow test
        apply_reset();
        test_overflow();
        test_bounds();
        test_counter_clear();
        test_unmapped();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
+incdir+sim
hdl/range_pkg.sv
hdl/sample_capture.sv
hdl/sample_fifo.sv
hdl/range_regs.sv
hdl/range_checker.sv
hdl/range_monitor_top.sv
sim/tb_range_monitor.sv

/* Bender.yml */
package:
  name: range_monitor

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/range_pkg.sv
      - hdl/sample_capture.sv
      - hdl/sample_fifo.sv
      - hdl/range_regs.sv
      - hdl/range_checker.sv
      - hdl/range_monitor_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/tb_range_monitor.sv
